/* hw/rv_pkg.sv */
//**************************************
// Shared types and encodings for the RV32I single-cycle core
// Import with rv_pkg::* in the module header
//**************************************
package rv_pkg;

  typedef logic [31:0] rv_word_t;
  typedef logic [6:0] rv_opcode_t;

  // Base opcodes used by the core
  localparam rv_opcode_t OPCODE_LOAD     = 7'b0000011;
  localparam rv_opcode_t OPCODE_MISC_MEM = 7'b0001111;
  localparam rv_opcode_t OPCODE_OP_IMM   = 7'b0010011;
  localparam rv_opcode_t OPCODE_AUIPC    = 7'b0010111;
  localparam rv_opcode_t OPCODE_STORE    = 7'b0100011;
  localparam rv_opcode_t OPCODE_OP       = 7'b0110011;
  localparam rv_opcode_t OPCODE_LUI      = 7'b0110111;
  localparam rv_opcode_t OPCODE_BRANCH   = 7'b1100011;
  localparam rv_opcode_t OPCODE_JALR     = 7'b1100111;
  localparam rv_opcode_t OPCODE_JAL      = 7'b1101111;

  // Next PC source
  localparam logic [1:0] CTL_PC_PC4     = 2'd0;
  localparam logic [1:0] CTL_PC_PC_IMM  = 2'd1;
  localparam logic [1:0] CTL_PC_RS1_IMM = 2'd2;

  // ALU operand sources
  localparam logic CTL_ALU_A_RS1 = 1'b0;
  localparam logic CTL_ALU_A_PC  = 1'b1;
  localparam logic CTL_ALU_B_RS2 = 1'b0;
  localparam logic CTL_ALU_B_IMM = 1'b1;

  // ALU op classes, refined by alu_control
  localparam logic [1:0] CTL_ALU_ADD    = 2'd0;
  localparam logic [1:0] CTL_ALU_OP     = 2'd1;
  localparam logic [1:0] CTL_ALU_OP_IMM = 2'd2;
  localparam logic [1:0] CTL_ALU_BRANCH = 2'd3;

  // Register writeback source
  localparam logic [2:0] CTL_WRITEBACK_ALU  = 3'd0;
  localparam logic [2:0] CTL_WRITEBACK_DATA = 3'd1;
  localparam logic [2:0] CTL_WRITEBACK_PC4  = 3'd2;
  localparam logic [2:0] CTL_WRITEBACK_IMM  = 3'd3;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
    OR, AND, EQ, NE, LT, GE, LTU, GEU
  } alu_func_t;

  // Instruction word, one view per format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      rv_opcode_t opcode;
    } r_type;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      rv_opcode_t  opcode;
    } i_type;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      rv_opcode_t opcode;
    } s_type;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      rv_opcode_t opcode;
    } b_type;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      rv_opcode_t  opcode;
    } u_type;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      rv_opcode_t opcode;
    } j_type;
  } rv_inst_u;

  typedef struct packed {
    logic [1:0] next_pc_select;
    logic       regfile_write_enable;
    logic       alu_operand_a_select;
    logic       alu_operand_b_select;
    logic [1:0] alu_op_type;
    logic       data_mem_read_enable;
    logic       data_mem_write_enable;
    logic [2:0] reg_writeback_select;
  } control_t;

  typedef struct packed {
    rv_word_t addr;
    rv_word_t wdata;
    logic     read_enable;
    logic     write_enable;
  } data_req_t;

endpackage

/* hw/alu.sv */
//**************************************
// 32-bit integer ALU
// Compare functions return 0 or 1, bit 0 drives branches
//**************************************
`timescale 1ns/1ps

module alu
  import rv_pkg::*;
(
  input  rv_word_t  operand_a,
  input  rv_word_t  operand_b,
  input  alu_func_t func,
  output rv_word_t  result
);

  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;
  logic [4:0] shamt;

  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;
  assign equal       = operand_a == operand_b;
  assign shamt       = operand_b[4:0];

  always_comb
  begin
    result = '0;
    case (func)
      ADD:  result = operand_a + operand_b;
      SUB:  result = operand_a - operand_b;
      SLL:  result = operand_a << shamt;
      SLT:  result = {31'b0, lt_signed};
      SLTU: result = {31'b0, lt_unsigned};
      XOR:  result = operand_a ^ operand_b;
      SRL:  result = operand_a >> shamt;
      SRA:  result = $signed(operand_a) >>> shamt;
      OR:   result = operand_a | operand_b;
      AND:  result = operand_a & operand_b;
      // Branch conditions
      EQ:   result = {31'b0, equal};
      NE:   result = {31'b0, !equal};
      LT:   result = {31'b0, lt_signed};
      GE:   result = {31'b0, !lt_signed};
      LTU:  result = {31'b0, lt_unsigned};
      GEU:  result = {31'b0, !lt_unsigned};
    endcase
  end

endmodule

/* hw/regfile.sv */
//**************************************
// Integer register file, 2 read and 1 write port
// Reads are combinational, x0 reads as zero
//**************************************
`timescale 1ns/1ps

module regfile
  import rv_pkg::*;
(
  input  logic       clock,
  input  logic [4:0] rs1_addr,
  input  logic [4:0] rs2_addr,
  input  logic [4:0] rd_addr,
  input  rv_word_t   rd_data,
  input  logic       write_enable,
  output rv_word_t   rs1_data,
  output rv_word_t   rs2_data
);

  // x0 has no storage
  rv_word_t regs [1:31];

  always_ff @(posedge clock)
  begin
    if (write_enable && rd_addr != 5'd0)
    begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* hw/imm_decoder.sv */
//**************************************
// Builds the sign-extended immediate
// Format is picked from the opcode
//**************************************
`timescale 1ns/1ps

module imm_decoder
  import rv_pkg::*;
(
  input  rv_inst_u inst,
  output rv_word_t imm
);

  always_comb
  begin
    case (inst.r_type.opcode)
      OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_JALR:
        imm = {{20{inst.i_type.imm[11]}}, inst.i_type.imm};
      OPCODE_STORE:
        imm = {{20{inst.s_type.imm_11_5[6]}}, inst.s_type.imm_11_5, inst.s_type.imm_4_0};
      OPCODE_BRANCH:
        imm = {{20{inst.b_type.imm_12}}, inst.b_type.imm_11, inst.b_type.imm_10_5,
               inst.b_type.imm_4_1, 1'b0};
      OPCODE_LUI, OPCODE_AUIPC:
        imm = {inst.u_type.imm_31_12, 12'b0};
      OPCODE_JAL:
        imm = {{12{inst.j_type.imm_20}}, inst.j_type.imm_19_12, inst.j_type.imm_11,
               inst.j_type.imm_10_1, 1'b0};
      // R-type and FENCE carry no immediate
      default:
        imm = '0;
    endcase
  end

endmodule

/* hw/singlecycle_control.sv */
//**************************************
// Main decoder of the single-cycle core
// Maps the opcode and branch outcome to control_t
//**************************************
`timescale 1ns/1ps

module singlecycle_control
  import rv_pkg::*;
(
  input  rv_opcode_t inst_opcode,
  input  logic       take_branch,
  output control_t   ctl
);

  always_comb
  begin
    // Unlisted opcodes leave state untouched and fall through to PC+4
    ctl.next_pc_select        = CTL_PC_PC4;
    ctl.regfile_write_enable  = 1'b0;
    ctl.alu_operand_a_select  = 1'bx;
    ctl.alu_operand_b_select  = 1'bx;
    ctl.alu_op_type           = 2'bxx;
    ctl.data_mem_read_enable  = 1'b0;
    ctl.data_mem_write_enable = 1'b0;
    ctl.reg_writeback_select  = 3'bxxx;

    case (inst_opcode)
      OPCODE_LOAD:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        ctl.alu_op_type          = CTL_ALU_ADD;
        ctl.data_mem_read_enable = 1'b1;
        ctl.reg_writeback_select = CTL_WRITEBACK_DATA;
      end
      OPCODE_MISC_MEM:
      begin
        // FENCE has nothing to order in this core
      end
      OPCODE_OP_IMM:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        ctl.alu_op_type          = CTL_ALU_OP_IMM;
        ctl.reg_writeback_select = CTL_WRITEBACK_ALU;
      end
      OPCODE_AUIPC:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_PC;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        ctl.alu_op_type          = CTL_ALU_ADD;
        ctl.reg_writeback_select = CTL_WRITEBACK_ALU;
      end
      OPCODE_STORE:
      begin
        ctl.alu_operand_a_select  = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select  = CTL_ALU_B_IMM;
        ctl.alu_op_type           = CTL_ALU_ADD;
        ctl.data_mem_write_enable = 1'b1;
      end
      OPCODE_OP:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select = CTL_ALU_B_RS2;
        ctl.alu_op_type          = CTL_ALU_OP;
        ctl.reg_writeback_select = CTL_WRITEBACK_ALU;
      end
      OPCODE_LUI:
      begin
        // Immediate goes straight to rd, ALU unused
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = CTL_WRITEBACK_IMM;
      end
      OPCODE_BRANCH:
      begin
        ctl.next_pc_select       = take_branch ? CTL_PC_PC_IMM : CTL_PC_PC4;
        ctl.alu_operand_a_select = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select = CTL_ALU_B_RS2;
        ctl.alu_op_type          = CTL_ALU_BRANCH;
      end
      OPCODE_JALR:
      begin
        ctl.next_pc_select       = CTL_PC_RS1_IMM;
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_RS1;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        ctl.alu_op_type          = CTL_ALU_ADD;
        ctl.reg_writeback_select = CTL_WRITEBACK_PC4;
      end
      OPCODE_JAL:
      begin
        ctl.next_pc_select       = CTL_PC_PC_IMM;
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_PC;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        ctl.alu_op_type          = CTL_ALU_ADD;
        ctl.reg_writeback_select = CTL_WRITEBACK_PC4;
      end
      default:
      begin
      end
    endcase
  end

endmodule

/* hw/alu_control.sv */
//**************************************
// Refines the ALU op class into an ALU function
// using funct3 and funct7 of the instruction
//**************************************
`timescale 1ns/1ps

module alu_control
  import rv_pkg::*;
(
  input  logic [1:0] alu_op_type,
  input  rv_inst_u   inst,
  output alu_func_t  alu_func
);

  // Shared funct3 table for OP and OP_IMM
  function automatic alu_func_t arith_func(input logic [2:0] funct3, input logic sub_sel,
                                           input logic sra_sel);
    case (funct3)
      3'b000:  return sub_sel ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return sra_sel ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  always_comb
  begin
    case (alu_op_type)
      CTL_ALU_OP:
        alu_func = arith_func(inst.r_type.funct3, inst.r_type.funct7[5], inst.r_type.funct7[5]);
      // No SUBI, so only SRAI looks at the upper immediate bit
      CTL_ALU_OP_IMM:
        alu_func = arith_func(inst.i_type.funct3, 1'b0, inst.i_type.imm[10]);
      CTL_ALU_BRANCH:
        case (inst.b_type.funct3)
          3'b000:  alu_func = EQ;
          3'b001:  alu_func = NE;
          3'b100:  alu_func = LT;
          3'b101:  alu_func = GE;
          3'b110:  alu_func = LTU;
          3'b111:  alu_func = GEU;
          default: alu_func = EQ;
        endcase
      default:
        alu_func = ADD;
    endcase
  end

endmodule

/* hw/singlecycle_datapath.sv */
//**************************************
// Single-cycle datapath: PC, register file, ALU,
// operand and writeback muxes, data-memory request
//**************************************
`timescale 1ns/1ps

module singlecycle_datapath
  import rv_pkg::*;
#(
  parameter rv_word_t RESET_PC = 32'h0
)
(
  input  logic      clock,
  input  logic      rst_n,
  input  control_t  ctl,
  input  alu_func_t alu_func,
  input  rv_inst_u  inst,
  input  rv_word_t  data_rdata,
  output logic      take_branch,
  output rv_word_t  inst_addr,
  output data_req_t data_req
);

  rv_word_t pc;
  rv_word_t pc_plus_4;
  rv_word_t branch_target;
  rv_word_t next_pc;
  rv_word_t imm;
  rv_word_t rs1_data;
  rv_word_t rs2_data;
  rv_word_t alu_operand_a;
  rv_word_t alu_operand_b;
  rv_word_t alu_result;
  rv_word_t writeback_data;
  logic     rd_write;

  regfile u_regfile (
    .clock        (clock),
    .rs1_addr     (inst.r_type.rs1),
    .rs2_addr     (inst.r_type.rs2),
    .rd_addr      (inst.r_type.rd),
    .rd_data      (writeback_data),
    .write_enable (rd_write),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  imm_decoder u_imm_decoder (
    .inst (inst),
    .imm  (imm)
  );

  assign alu_operand_a = (ctl.alu_operand_a_select == CTL_ALU_A_PC) ? pc : rs1_data;
  assign alu_operand_b = (ctl.alu_operand_b_select == CTL_ALU_B_IMM) ? imm : rs2_data;

  alu u_alu (
    .operand_a (alu_operand_a),
    .operand_b (alu_operand_b),
    .func      (alu_func),
    .result    (alu_result)
  );

  assign take_branch = alu_result[0];

  // Branches need their own adder since the ALU does the compare
  assign pc_plus_4     = pc + 32'd4;
  assign branch_target = pc + imm;

  always_comb
  begin
    case (ctl.next_pc_select)
      CTL_PC_PC_IMM:  next_pc = branch_target;
      // JALR sum comes from the ALU, bit 0 dropped
      CTL_PC_RS1_IMM: next_pc = {alu_result[31:1], 1'b0};
      default:        next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      pc <= RESET_PC;
    end
    else
    begin
      pc <= next_pc;
    end
  end

  assign inst_addr = pc;

  always_comb
  begin
    case (ctl.reg_writeback_select)
      CTL_WRITEBACK_DATA: writeback_data = data_rdata;
      CTL_WRITEBACK_PC4:  writeback_data = pc_plus_4;
      CTL_WRITEBACK_IMM:  writeback_data = imm;
      default:            writeback_data = alu_result;
    endcase
  end

  // No architectural update while in reset
  assign rd_write = ctl.regfile_write_enable & rst_n;

  assign data_req.addr         = alu_result;
  assign data_req.wdata        = rs2_data;
  assign data_req.read_enable  = ctl.data_mem_read_enable;
  assign data_req.write_enable = ctl.data_mem_write_enable & rst_n;

endmodule

/* hw/singlecycle_core.sv */
//**************************************
// RV32I single-cycle core, top level
// One instruction retires per clock edge
//**************************************
`timescale 1ns/1ps

module singlecycle_core
  import rv_pkg::*;
#(
  parameter rv_word_t RESET_PC = 32'h0
)
(
  input  logic      clock,
  input  logic      rst_n,
  input  rv_inst_u  inst_data,
  input  rv_word_t  data_rdata,
  output rv_word_t  inst_addr,
  output data_req_t data_req
);

  control_t  ctl;
  alu_func_t alu_func;
  logic      take_branch;

  singlecycle_control u_control (
    .inst_opcode (inst_data.r_type.opcode),
    .take_branch (take_branch),
    .ctl         (ctl)
  );

  alu_control u_alu_control (
    .alu_op_type (ctl.alu_op_type),
    .inst        (inst_data),
    .alu_func    (alu_func)
  );

  singlecycle_datapath #(
    .RESET_PC (RESET_PC)
  ) u_datapath (
    .clock       (clock),
    .rst_n       (rst_n),
    .ctl         (ctl),
    .alu_func    (alu_func),
    .inst        (inst_data),
    .data_rdata  (data_rdata),
    .take_branch (take_branch),
    .inst_addr   (inst_addr),
    .data_req    (data_req)
  );

endmodule

/* tests/core_assertions.sv */
//****************************************
// Concurrent checks on the core's memory ports
// Attached to singlecycle_core by the bind below
//****************************************
`timescale 1ns/1ps

module core_assertions
  import rv_pkg::*;
#(
  parameter rv_word_t RESET_PC = 32'h0
)
(
  input logic      clock,
  input logic      rst_n,
  input rv_word_t  inst_addr,
  input data_req_t data_req
);

  int fail_count = 0;

  read_write_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
    !(data_req.read_enable && data_req.write_enable))
  else
  begin
    $error("data memory read and write requested in the same cycle");
    fail_count++;
  end

  no_store_in_reset: assert property (@(posedge clock)
    !rst_n |-> !data_req.write_enable)
  else
  begin
    $error("store requested while in reset");
    fail_count++;
  end

  fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    inst_addr[1:0] == 2'b00)
  else
  begin
    $error("instruction address not word aligned");
    fail_count++;
  end

  // First fetch after release comes from the reset vector
  first_fetch_at_reset_pc: assert property (@(posedge clock)
    $rose(rst_n) |-> inst_addr == RESET_PC)
  else
  begin
    $error("first fetch after reset not at the reset vector");
    fail_count++;
  end

endmodule

bind singlecycle_core core_assertions #(
  .RESET_PC (RESET_PC)
) u_core_assertions (
  .clock     (clock),
  .rst_n     (rst_n),
  .inst_addr (inst_addr),
  .data_req  (data_req)
);

/* tests/tb_core.sv */
//****************************************
// Testbench for the single-cycle RV32I core
// Runs a random program and checks it against an ISA model
//****************************************
`timescale 1ns/1ps

module tb_core
  import rv_pkg::*;
();

  localparam rv_word_t RESET_PC = 32'h0;

  typedef rv_word_t reg_array_t [32];
  typedef rv_word_t mem_array_t [64];

  logic       clock;
  logic       rst_n;
  rv_inst_u   inst_data;
  rv_word_t   data_rdata;
  rv_word_t   inst_addr;
  data_req_t  data_req;

  rv_word_t   imem [256];
  mem_array_t dmem;
  mem_array_t model_mem;
  reg_array_t model_regs;
  rv_word_t   model_pc;
  rv_word_t   loop_pc;
  integer     seed;
  int         mismatch_count;
  int         timeout_count;

  singlecycle_core #(
    .RESET_PC (RESET_PC)
  ) singlecycle_core_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst_data  (inst_data),
    .data_rdata (data_rdata),
    .inst_addr  (inst_addr),
    .data_req   (data_req)
  );

  // Both memories answer within the cycle
  assign inst_data  = imem[inst_addr[9:2]];
  assign data_rdata = dmem[data_req.addr[7:2]];

  always @(posedge clock)
  begin
    if (data_req.write_enable)
    begin
      dmem[data_req.addr[7:2]] <= data_req.wdata;
    end
  end

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic rv_word_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input rv_opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv_word_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input rv_opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_word_t b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic rv_word_t j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  // SW rs2 to a data word addressed off x0
  function automatic rv_word_t store_word(input logic [4:0] rs2, input logic [5:0] index);
    logic [11:0] imm;
    imm = {4'b0, index, 2'b00};
    return r_word(imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPCODE_STORE);
  endfunction

  // One random instruction that never changes control flow
  function automatic rv_word_t random_simple();
    rv_word_t    r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    r   = $random(seed);
    rd  = {2'b0, r[2:0]};
    rs1 = {2'b0, r[5:3]};
    rs2 = {2'b0, r[8:6]};
    f3  = r[11:9];
    imm = r[31:20];
    case (r[15:12])
      4'd0, 4'd1, 4'd2:
      begin
        if (f3 == 3'b001)
          imm = {7'b0, imm[4:0]};
        else if (f3 == 3'b101)
          imm = {1'b0, r[16], 5'b0, imm[4:0]};
        return i_word(imm, rs1, f3, rd, OPCODE_OP_IMM);
      end
      4'd3, 4'd4, 4'd5:
        return r_word({1'b0, r[16] && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                      rs2, rs1, f3, rd, OPCODE_OP);
      4'd6:    return {r[31:12], rd, OPCODE_LUI};
      4'd7:    return {r[31:12], rd, OPCODE_AUIPC};
      4'd8, 4'd9:
        return store_word(rs2, r[25:20]);
      4'd10, 4'd11:
        return i_word({4'b0, r[25:20], 2'b00}, 5'd0, 3'b010, rd, OPCODE_LOAD);
      4'd12:   return i_word(12'h0ff, 5'd0, 3'b000, 5'd0, OPCODE_MISC_MEM);
      // Custom-0 opcode, undefined for this core
      4'd13:   return {r[31:7], 7'b0001011};
      default: return i_word(imm, rs1, 3'b000, rd, OPCODE_OP_IMM);
    endcase
  endfunction

  task automatic build_program();
    int          k;
    int          skip;
    rv_word_t    sel;
    rv_word_t    target;
    rv_word_t    hi;
    logic [2:0]  f3;
    k = 0;
    // Registers x1 to x7 get defined values first
    for (int r = 1; r < 8; r++)
    begin
      sel = $random(seed);
      imem[k] = {sel[19:0], r[4:0], OPCODE_LUI};
      k++;
    end
    while (k < 230)
    begin
      sel  = $random(seed);
      skip = sel[7] ? 2 : 1;
      case (sel[3:0])
        4'd0:
        begin
          f3 = sel[6:4];
          if (f3[2:1] == 2'b01)
            f3 = f3 + 3'd2;
          imem[k] = b_word(13'((skip + 1) * 4), {2'b0, sel[10:8]}, {2'b0, sel[13:11]}, f3);
          k++;
        end
        4'd1:
        begin
          imem[k] = j_word(21'((skip + 1) * 4), {2'b0, sel[10:8]});
          k++;
        end
        4'd2:
        begin
          // Target skips one instruction, odd offset checks bit 0 clearing
          skip    = 1;
          target  = (k + 4) * 4;
          hi      = (target + 32'h800) >> 12;
          imem[k] = {hi[19:0], 5'd6, OPCODE_LUI};
          imem[k + 1] = i_word(target[11:0], 5'd6, 3'b000, 5'd6, OPCODE_OP_IMM);
          imem[k + 2] = i_word(12'd1, 5'd6, 3'b000, 5'd5, OPCODE_JALR);
          k += 3;
        end
        default:
          skip = 0;
      endcase
      for (int i = 0; i <= skip; i++)
      begin
        imem[k] = random_simple();
        k++;
      end
    end
    for (int r = 0; r < 8; r++)
    begin
      imem[k] = store_word(r[4:0], 6'(56 + r));
      k++;
    end
    imem[k] = j_word(21'd0, 5'd0);
    loop_pc = k * 4;
  endtask

  function automatic rv_word_t arith(input logic [2:0] f3, input rv_word_t a,
                                     input rv_word_t b, input logic alt);
    case (f3)
      3'b000:  if (alt) return a - b; else return a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA model of one instruction, rd of zero means no register update
  function automatic void ref_step(input rv_word_t pc, input reg_array_t regs,
                                   input mem_array_t mem, output rv_word_t next_pc,
                                   output logic [4:0] rd, output rv_word_t rd_val,
                                   output data_req_t store);
    logic [31:0] w;
    rv_word_t    a;
    rv_word_t    b;
    rv_word_t    imm_i;
    rv_word_t    ea;
    logic        cond;
    logic        wr;
    w       = imem[pc[9:2]];
    a       = regs[w[19:15]];
    b       = regs[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    next_pc = pc + 32'd4;
    rd      = w[11:7];
    rd_val  = '0;
    wr      = 1'b1;
    store   = '0;
    case (w[6:0])
      OPCODE_LUI:    rd_val = {w[31:12], 12'b0};
      OPCODE_AUIPC:  rd_val = pc + {w[31:12], 12'b0};
      OPCODE_OP_IMM: rd_val = arith(w[14:12], a, imm_i, w[14:12] == 3'b101 && w[30]);
      OPCODE_OP:     rd_val = arith(w[14:12], a, b, w[30]);
      OPCODE_JAL:
      begin
        rd_val  = pc + 32'd4;
        next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPCODE_JALR:
      begin
        rd_val  = pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      OPCODE_BRANCH:
      begin
        wr = 1'b0;
        case (w[14:12])
          3'b000:  cond = a == b;
          3'b001:  cond = a != b;
          3'b100:  cond = $signed(a) < $signed(b);
          3'b101:  cond = $signed(a) >= $signed(b);
          3'b110:  cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond)
          next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      OPCODE_LOAD:
      begin
        ea                = a + imm_i;
        rd_val            = mem[ea[7:2]];
        store.addr        = ea;
        store.read_enable = 1'b1;
      end
      OPCODE_STORE:
      begin
        wr                 = 1'b0;
        store.addr         = a + {{20{w[31]}}, w[31:25], w[11:7]};
        store.wdata        = b;
        store.write_enable = 1'b1;
      end
      // FENCE and undefined opcodes change nothing
      default: wr = 1'b0;
    endcase
    if (!wr)
      rd = 5'd0;
  endfunction

  task automatic compare_word(input string name, input rv_word_t got, input rv_word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic compare_req(input string name, input data_req_t got, input data_req_t exp);
    if (got.write_enable !== exp.write_enable)
    begin
      $display("MISMATCH time=%0t %s.write_enable got=%b exp=%b", $time, name,
               got.write_enable, exp.write_enable);
      mismatch_count++;
    end
    else if (exp.write_enable)
    begin
      compare_word({name, ".addr"}, got.addr, exp.addr);
      compare_word({name, ".wdata"}, got.wdata, exp.wdata);
    end
    if (got.read_enable !== exp.read_enable)
    begin
      $display("MISMATCH time=%0t %s.read_enable got=%b exp=%b", $time, name,
               got.read_enable, exp.read_enable);
      mismatch_count++;
    end
    else if (exp.read_enable)
    begin
      compare_word({name, ".addr"}, got.addr, exp.addr);
    end
  endtask

  always @(negedge clock)
  begin
    rv_word_t   next_pc;
    logic [4:0] rd;
    rv_word_t   rd_val;
    data_req_t  store;
    if (!rst_n)
    begin
      // Store held off, the load request still follows the decode
      ref_step(model_pc, model_regs, model_mem, next_pc, rd, rd_val, store);
      store.write_enable = 1'b0;
      compare_req("data_req", data_req, store);
    end
    else
    begin
      compare_word("inst_addr", inst_addr, model_pc);
      ref_step(model_pc, model_regs, model_mem, next_pc, rd, rd_val, store);
      compare_req("data_req", data_req, store);
      if (rd != 5'd0)
        model_regs[rd] = rd_val;
      if (store.write_enable)
        model_mem[store.addr[7:2]] = store.wdata;
      model_pc = next_pc;
    end
  end

  initial
  begin
    int cycles;
    seed           = 32'h6ab9;
    mismatch_count = 0;
    timeout_count  = 0;
    rst_n          = 1'b0;
    model_pc       = RESET_PC;
    for (int i = 0; i < 256; i++)
      imem[i] = i_word(12'(i), 5'd0, 3'b000, 5'd0, OPCODE_OP_IMM);
    for (int i = 0; i < 64; i++)
    begin
      dmem[i]      = 32'h5a5a_0000 ^ (i * 32'h9e37_79b9);
      model_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    build_program();

    repeat (2) @(posedge clock);
    rst_n <= 1'b1;

    cycles = 0;
    while (inst_addr !== loop_pc && cycles < 2000)
    begin
      @(negedge clock);
      cycles++;
    end
    if (cycles >= 2000)
    begin
      $display("Timeout: the core did not reach the final loop at %h in 2000 cycles", loop_pc);
      timeout_count++;
    end
    else
    begin
      for (int i = 0; i < 64; i++)
        compare_word($sformatf("dmem[%0d]", i), dmem[i], model_mem[i]);
    end

    $display("Mismatches: %0d, timeouts: %0d, assertion failures: %0d", mismatch_count,
             timeout_count, singlecycle_core_i.u_core_assertions.fail_count);
    if (mismatch_count == 0 && timeout_count == 0 &&
        singlecycle_core_i.u_core_assertions.fail_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* list.f */
hw/rv_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/imm_decoder.sv
hw/singlecycle_control.sv
hw/alu_control.sv
hw/singlecycle_datapath.sv
hw/singlecycle_core.sv
tests/core_assertions.sv
tests/tb_core.sv

/* Bender.yml */
package:
  name: rv32i_singlecycle

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/alu.sv
      - hw/regfile.sv
      - hw/imm_decoder.sv
      - hw/singlecycle_control.sv
      - hw/alu_control.sv
      - hw/singlecycle_datapath.sv
      - hw/singlecycle_core.sv
  - target: test
    files:
      - tests/core_assertions.sv
      - tests/tb_core.sv
